//--- design/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and register file
`define CORE_XLEN 32
`define CORE_REG_NUM 32
`define CORE_REG_ID_WIDTH 5

// instruction queue entries
`define CORE_INST_FIFO_DEPTH 4

// multiplier latency in cycles
`define CORE_MUL_STAGES 3

`endif

//--- design/core_pkg.sv
`include "core_settings.svh"

package core_pkg;
    typedef enum logic[3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_lui_pass
    } alu_op_e;

    typedef enum logic {
        mul_lo,
        mul_hu
    } mul_op_e;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

    typedef struct packed {
        unit_e unit;
        alu_op_e alu_op;
        mul_op_e mul_op;
        logic[`CORE_REG_ID_WIDTH - 1:0] rs1;
        logic[`CORE_REG_ID_WIDTH - 1:0] rs2;
        logic[`CORE_REG_ID_WIDTH - 1:0] rd;
        logic use_imm;
        logic[`CORE_XLEN - 1:0] imm;
        // low when rd is x0
        logic writes_rd;
    } decode_pack_t;

    typedef struct packed {
        alu_op_e alu_op;
        mul_op_e mul_op;
        logic[`CORE_XLEN - 1:0] a;
        logic[`CORE_XLEN - 1:0] b;
        logic[`CORE_REG_ID_WIDTH - 1:0] rd;
        logic writes_rd;
    } exec_pack_t;

    typedef struct packed {
        logic[`CORE_REG_ID_WIDTH - 1:0] rd;
        logic[`CORE_XLEN - 1:0] data;
        logic writes_rd;
    } wb_pack_t;
endpackage

//--- design/inst_fifo.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module inst_fifo(
        input logic clk,
        input logic arst_n,
        input logic[`CORE_XLEN - 1:0] in_data,
        input logic in_valid,
        output logic in_ready,
        output logic[`CORE_XLEN - 1:0] out_data,
        output logic out_valid,
        input logic out_ready
    );

    localparam int DEPTH = `CORE_INST_FIFO_DEPTH;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic[`CORE_XLEN - 1:0] mem[0:DEPTH - 1];
    logic[PTR_WIDTH - 1:0] wr_ptr;
    logic[PTR_WIDTH - 1:0] rd_ptr;
    logic[CNT_WIDTH - 1:0] count;
    logic push;
    logic pop;

    function automatic logic[PTR_WIDTH - 1:0] ptr_next(input logic[PTR_WIDTH - 1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready = count != CNT_WIDTH'(DEPTH);
    assign out_valid = count != '0;
    assign out_data = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if(push) wr_ptr <= ptr_next(wr_ptr);
            if(pop) rd_ptr <= ptr_next(rd_ptr);
            if(push && !pop) count <= count + 1'b1;
            else if(pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if(push) mem[wr_ptr] <= in_data;
    end
endmodule

//--- design/decode.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module decode(
        input logic clk,
        input logic arst_n,
        input logic[`CORE_XLEN - 1:0] in_data,
        input logic in_valid,
        output logic in_ready,
        output core_pkg::decode_pack_t out_pack,
        output logic out_valid,
        input logic out_ready,
        output logic illegal
    );
    import core_pkg::*;

    typedef enum logic[6:0] {
        opc_op = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui = 7'b0110111
    } rv_opcode_e;

    rv_opcode_e opcode;
    logic[2:0] funct3;
    logic[6:0] funct7;
    decode_pack_t dec;
    logic legal;

    // alt selects sub and sra
    function automatic alu_op_e alu_op_sel(input logic[2:0] f3, input logic alt);
        case(f3)
            3'b000: return alt ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = rv_opcode_e'(in_data[6:0]);
    assign funct3 = in_data[14:12];
    assign funct7 = in_data[31:25];

    always_comb begin
        dec = '0;
        dec.rs1 = in_data[19:15];
        dec.rs2 = in_data[24:20];
        dec.rd = in_data[11:7];
        dec.writes_rd = in_data[11:7] != '0;
        dec.imm = {{20{in_data[31]}}, in_data[31:20]};
        legal = 1'b0;

        case(opcode)
            opc_op: begin
                dec.alu_op = alu_op_sel(funct3, funct7[5]);
                dec.mul_op = (funct3 == 3'b011) ? mul_hu : mul_lo;
                if(funct7 == 7'b0000001) begin
                    dec.unit = unit_mul;
                    legal = funct3 == 3'b000 || funct3 == 3'b011;
                end else begin
                    legal = funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                end
            end
            opc_op_imm: begin
                // no second source register
                dec.rs2 = '0;
                dec.use_imm = 1'b1;
                dec.alu_op = alu_op_sel(funct3, funct3 == 3'b101 && funct7[5]);
                if(funct3 == 3'b001) legal = funct7 == 7'b0000000;
                else if(funct3 == 3'b101) legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                else legal = 1'b1;
            end
            opc_lui: begin
                dec.rs1 = '0;
                dec.rs2 = '0;
                dec.use_imm = 1'b1;
                dec.imm = {in_data[31:12], 12'b0};
                dec.alu_op = alu_lui_pass;
                legal = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // output register drains or is empty
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) begin
            out_valid <= 1'b0;
            illegal <= 1'b0;
        end else begin
            illegal <= in_valid && in_ready && !legal;
            if(in_ready) out_valid <= in_valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if(in_valid && in_ready && legal) out_pack <= dec;
    end
endmodule

//--- design/regfile.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module regfile(
        input logic clk,
        input logic arst_n,
        input logic[`CORE_REG_ID_WIDTH - 1:0] rs1,
        input logic[`CORE_REG_ID_WIDTH - 1:0] rs2,
        output logic[`CORE_XLEN - 1:0] rs1_data,
        output logic[`CORE_XLEN - 1:0] rs2_data,
        output logic rs1_busy,
        output logic rs2_busy,
        input logic[`CORE_REG_ID_WIDTH - 1:0] rd_busy_id,
        output logic rd_busy,
        input logic set_busy,
        input logic[`CORE_REG_ID_WIDTH - 1:0] set_busy_rd,
        input logic wr_en,
        input logic[`CORE_REG_ID_WIDTH - 1:0] wr_rd,
        input logic[`CORE_XLEN - 1:0] wr_data
    );

    logic[`CORE_XLEN - 1:0] regs[0:`CORE_REG_NUM - 1];
    logic[`CORE_REG_NUM - 1:0] busy;

    // x0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) begin
            for(int i = 0;i < `CORE_REG_NUM;i++) regs[i] <= '0;
        end else if(wr_en && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // a set in the same cycle overrides the clear
    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) begin
            busy <= '0;
        end else begin
            if(wr_en) busy[wr_rd] <= 1'b0;
            if(set_busy && set_busy_rd != '0) busy[set_busy_rd] <= 1'b1;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];
    assign rd_busy = busy[rd_busy_id];
endmodule

//--- design/issue.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module issue(
        input core_pkg::decode_pack_t in_pack,
        input logic in_valid,
        output logic in_ready,
        output logic[`CORE_REG_ID_WIDTH - 1:0] rs1,
        output logic[`CORE_REG_ID_WIDTH - 1:0] rs2,
        input logic[`CORE_XLEN - 1:0] rs1_data,
        input logic[`CORE_XLEN - 1:0] rs2_data,
        input logic rs1_busy,
        input logic rs2_busy,
        output logic[`CORE_REG_ID_WIDTH - 1:0] rd_busy_id,
        input logic rd_busy,
        output logic set_busy,
        output logic[`CORE_REG_ID_WIDTH - 1:0] set_busy_rd,
        output core_pkg::exec_pack_t alu_pack,
        output logic alu_valid,
        input logic alu_ready,
        output core_pkg::exec_pack_t mul_pack,
        output logic mul_valid,
        input logic mul_ready
    );
    import core_pkg::*;

    logic hazard;
    logic unit_ready;
    logic fire;
    exec_pack_t exec;

    assign rs1 = in_pack.rs1;
    assign rs2 = in_pack.rs2;
    assign rd_busy_id = in_pack.rd;

    // raw on either source, waw on rd
    assign hazard = rs1_busy || rs2_busy || rd_busy;
    assign unit_ready = (in_pack.unit == unit_alu) ? alu_ready : mul_ready;
    assign in_ready = !hazard && unit_ready;
    assign fire = in_valid && in_ready;

    assign exec.alu_op = in_pack.alu_op;
    assign exec.mul_op = in_pack.mul_op;
    assign exec.a = rs1_data;
    assign exec.b = in_pack.use_imm ? in_pack.imm : rs2_data;
    assign exec.rd = in_pack.rd;
    assign exec.writes_rd = in_pack.writes_rd;

    assign alu_pack = exec;
    assign mul_pack = exec;
    assign alu_valid = in_valid && !hazard && in_pack.unit == unit_alu;
    assign mul_valid = in_valid && !hazard && in_pack.unit == unit_mul;

    assign set_busy = fire && in_pack.writes_rd;
    assign set_busy_rd = in_pack.rd;
endmodule

//--- design/execute_alu.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module execute_alu(
        input logic clk,
        input logic arst_n,
        input core_pkg::exec_pack_t in_pack,
        input logic in_valid,
        output logic in_ready,
        output core_pkg::wb_pack_t out_pack,
        output logic out_valid,
        input logic out_ready
    );
    import core_pkg::*;

    logic[`CORE_XLEN - 1:0] a;
    logic[`CORE_XLEN - 1:0] b;
    logic[4:0] shamt;
    logic[`CORE_XLEN - 1:0] result;

    assign a = in_pack.a;
    assign b = in_pack.b;
    assign shamt = b[4:0];

    always_comb begin
        case(in_pack.alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_sll: result = a << shamt;
            alu_slt: result = `CORE_XLEN'($signed(a) < $signed(b));
            alu_sltu: result = `CORE_XLEN'(a < b);
            alu_xor: result = a ^ b;
            alu_srl: result = a >> shamt;
            alu_sra: result = $signed(a) >>> shamt;
            alu_or: result = a | b;
            alu_and: result = a & b;
            default: result = b;
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) out_valid <= 1'b0;
        else if(in_ready) out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if(in_valid && in_ready) begin
            out_pack.rd <= in_pack.rd;
            out_pack.data <= result;
            out_pack.writes_rd <= in_pack.writes_rd;
        end
    end
endmodule

//--- design/execute_mul.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module execute_mul(
        input logic clk,
        input logic arst_n,
        input core_pkg::exec_pack_t in_pack,
        input logic in_valid,
        output logic in_ready,
        output core_pkg::wb_pack_t out_pack,
        output logic out_valid,
        input logic out_ready
    );
    import core_pkg::*;

    localparam int STAGES = `CORE_MUL_STAGES;

    typedef struct packed {
        mul_op_e op;
        logic[2 * `CORE_XLEN - 1:0] prod;
        logic[`CORE_REG_ID_WIDTH - 1:0] rd;
        logic writes_rd;
    } mul_stage_t;

    mul_stage_t stage[0:STAGES - 1];
    logic[STAGES - 1:0] stage_valid;
    logic advance;

    // whole pipe holds when the last stage is blocked
    assign advance = !stage_valid[STAGES - 1] || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk or negedge arst_n) begin
        if(!arst_n) begin
            stage_valid <= '0;
        end else if(advance) begin
            stage_valid[0] <= in_valid;
            for(int i = 1;i < STAGES;i++) stage_valid[i] <= stage_valid[i - 1];
        end
    end

    always_ff @(posedge clk) begin
        if(advance) begin
            stage[0].op <= in_pack.mul_op;
            stage[0].prod <= in_pack.a * in_pack.b;
            stage[0].rd <= in_pack.rd;
            stage[0].writes_rd <= in_pack.writes_rd;
            for(int i = 1;i < STAGES;i++) stage[i] <= stage[i - 1];
        end
    end

    // unsigned product, low half is the same for mul
    assign out_valid = stage_valid[STAGES - 1];
    assign out_pack.rd = stage[STAGES - 1].rd;
    assign out_pack.writes_rd = stage[STAGES - 1].writes_rd;
    assign out_pack.data = (stage[STAGES - 1].op == mul_hu) ?
        stage[STAGES - 1].prod[2 * `CORE_XLEN - 1:`CORE_XLEN] :
        stage[STAGES - 1].prod[`CORE_XLEN - 1:0];
endmodule

//--- design/wb.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module wb(
        input core_pkg::wb_pack_t alu_pack,
        input logic alu_valid,
        output logic alu_ready,
        input core_pkg::wb_pack_t mul_pack,
        input logic mul_valid,
        output logic mul_ready,
        output logic wr_en,
        output logic[`CORE_REG_ID_WIDTH - 1:0] wr_rd,
        output logic[`CORE_XLEN - 1:0] wr_data,
        output logic retire_valid,
        output logic[`CORE_REG_ID_WIDTH - 1:0] retire_rd,
        output logic[`CORE_XLEN - 1:0] retire_data
    );
    import core_pkg::*;

    wb_pack_t sel;

    // multiplier first, alu waits behind it
    assign mul_ready = 1'b1;
    assign alu_ready = !mul_valid;
    assign sel = mul_valid ? mul_pack : alu_pack;

    assign wr_en = (mul_valid || alu_valid) && sel.writes_rd;
    assign wr_rd = sel.rd;
    assign wr_data = sel.data;

    assign retire_valid = wr_en;
    assign retire_rd = sel.rd;
    assign retire_data = sel.data;
endmodule

//--- design/core_top.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core_top(
        input logic clk,
        input logic arst_n,
        input logic[`CORE_XLEN - 1:0] inst,
        input logic inst_valid,
        output logic inst_ready,
        output logic retire_valid,
        output logic[`CORE_REG_ID_WIDTH - 1:0] retire_rd,
        output logic[`CORE_XLEN - 1:0] retire_data,
        output logic illegal
    );
    import core_pkg::*;

    //inst_fifo<->decode
    logic[`CORE_XLEN - 1:0] fifo_dec_data;
    logic fifo_dec_valid;
    logic fifo_dec_ready;

    //decode<->issue
    decode_pack_t dec_iss_pack;
    logic dec_iss_valid;
    logic dec_iss_ready;

    //issue<->regfile
    logic[`CORE_REG_ID_WIDTH - 1:0] rs1;
    logic[`CORE_REG_ID_WIDTH - 1:0] rs2;
    logic[`CORE_XLEN - 1:0] rs1_data;
    logic[`CORE_XLEN - 1:0] rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    logic[`CORE_REG_ID_WIDTH - 1:0] rd_busy_id;
    logic rd_busy;
    logic set_busy;
    logic[`CORE_REG_ID_WIDTH - 1:0] set_busy_rd;

    //wb<->regfile
    logic wr_en;
    logic[`CORE_REG_ID_WIDTH - 1:0] wr_rd;
    logic[`CORE_XLEN - 1:0] wr_data;

    //issue<->execute
    exec_pack_t iss_alu_pack;
    logic iss_alu_valid;
    logic iss_alu_ready;
    exec_pack_t iss_mul_pack;
    logic iss_mul_valid;
    logic iss_mul_ready;

    //execute<->wb
    wb_pack_t alu_wb_pack;
    logic alu_wb_valid;
    logic alu_wb_ready;
    wb_pack_t mul_wb_pack;
    logic mul_wb_valid;
    logic mul_wb_ready;

    inst_fifo inst_fifo_inst(.*,
        .in_data(inst), .in_valid(inst_valid), .in_ready(inst_ready),
        .out_data(fifo_dec_data), .out_valid(fifo_dec_valid), .out_ready(fifo_dec_ready));

    decode decode_inst(.*,
        .in_data(fifo_dec_data), .in_valid(fifo_dec_valid), .in_ready(fifo_dec_ready),
        .out_pack(dec_iss_pack), .out_valid(dec_iss_valid), .out_ready(dec_iss_ready));

    regfile regfile_inst(.*);

    issue issue_inst(.*,
        .in_pack(dec_iss_pack), .in_valid(dec_iss_valid), .in_ready(dec_iss_ready),
        .alu_pack(iss_alu_pack), .alu_valid(iss_alu_valid), .alu_ready(iss_alu_ready),
        .mul_pack(iss_mul_pack), .mul_valid(iss_mul_valid), .mul_ready(iss_mul_ready));

    execute_alu execute_alu_inst(.*,
        .in_pack(iss_alu_pack), .in_valid(iss_alu_valid), .in_ready(iss_alu_ready),
        .out_pack(alu_wb_pack), .out_valid(alu_wb_valid), .out_ready(alu_wb_ready));

    execute_mul execute_mul_inst(.*,
        .in_pack(iss_mul_pack), .in_valid(iss_mul_valid), .in_ready(iss_mul_ready),
        .out_pack(mul_wb_pack), .out_valid(mul_wb_valid), .out_ready(mul_wb_ready));

    wb wb_inst(.*,
        .alu_pack(alu_wb_pack), .alu_valid(alu_wb_valid), .alu_ready(alu_wb_ready),
        .mul_pack(mul_wb_pack), .mul_valid(mul_wb_valid), .mul_ready(mul_wb_ready));
endmodule

//--- dv/core_top_tb.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core_top_tb;
    typedef enum {
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra,
        op_or, op_and, op_mul, op_mulhu, op_lui
    } op_kind_e;

    typedef struct packed {
        logic[31:0] word;
        logic[7:0] gap;
        logic is_illegal;
    } row_t;

    logic clk;
    logic arst_n;
    logic[`CORE_XLEN - 1:0] inst;
    logic inst_valid;
    logic inst_ready;
    logic retire_valid;
    logic[`CORE_REG_ID_WIDTH - 1:0] retire_rd;
    logic[`CORE_XLEN - 1:0] retire_data;
    logic illegal;

    row_t rows[$];
    logic[31:0] model_regs[`CORE_REG_NUM];
    logic[31:0] expected[`CORE_REG_NUM][$];
    logic[31:0] lcg_state = 32'd40118;
    int errors = 0;
    int illegal_rows = 0;
    int illegal_seen = 0;
    logic ready_low_seen = 1'b0;

    core_top core_top_inst(.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic[31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic[31:0] got,
            input logic[31:0] exp);
        if(got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // RISC-V rules for the rd value
    function automatic logic[31:0] model_result(input op_kind_e k, input logic[31:0] a,
            input logic[31:0] b);
        logic[63:0] wide;
        wide = {32'b0, a} * {32'b0, b};
        case(k)
            op_add: return a + b;
            op_sub: return a - b;
            op_sll: return a << b[4:0];
            op_slt: return {31'b0, $signed(a) < $signed(b)};
            op_sltu: return {31'b0, a < b};
            op_xor: return a ^ b;
            op_srl: return a >> b[4:0];
            op_sra: return $signed(a) >>> b[4:0];
            op_or: return a | b;
            op_and: return a & b;
            op_mul: return wide[31:0];
            op_mulhu: return wide[63:32];
            default: return b;
        endcase
    endfunction

    function automatic logic[31:0] encode(input op_kind_e k, input logic use_imm, input int rd,
            input int rs1, input int rs2, input logic[31:0] imm);
        logic[2:0] f3;
        logic[6:0] f7;
        case(k)
            op_sll: f3 = 3'd1;
            op_slt: f3 = 3'd2;
            op_sltu, op_mulhu: f3 = 3'd3;
            op_xor: f3 = 3'd4;
            op_srl, op_sra: f3 = 3'd5;
            op_or: f3 = 3'd6;
            op_and: f3 = 3'd7;
            default: f3 = 3'd0;
        endcase
        f7 = (k == op_sub || k == op_sra) ? 7'h20 : (k == op_mul || k == op_mulhu) ? 7'h01 : 7'h00;
        if(k == op_lui) return {imm[31:12], 5'(rd), 7'h37};
        if(use_imm && (k == op_sll || k == op_srl || k == op_sra))
            return {f7, imm[4:0], 5'(rs1), f3, 5'(rd), 7'h13};
        if(use_imm) return {imm[11:0], 5'(rs1), f3, 5'(rd), 7'h13};
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    // runs the op on the model registers in program order
    task automatic add_op(input op_kind_e k, input logic use_imm, input int rd, input int rs1,
            input int rs2, input logic[31:0] imm, input int gap);
        logic[31:0] b;
        logic[31:0] value;
        row_t row;
        if(k == op_lui) b = {imm[31:12], 12'b0};
        else if(use_imm && (k == op_sll || k == op_srl || k == op_sra)) b = {27'b0, imm[4:0]};
        else if(use_imm) b = {{20{imm[11]}}, imm[11:0]};
        else b = model_regs[rs2];
        value = model_result(k, model_regs[rs1], b);
        row.word = encode(k, use_imm, rd, rs1, rs2, imm);
        row.gap = 8'(gap);
        row.is_illegal = 1'b0;
        rows.push_back(row);
        if(rd != 0) begin
            model_regs[rd] = value;
            expected[rd].push_back(value);
        end
    endtask

    task automatic add_illegal(input logic[31:0] word, input int gap);
        row_t row;
        row.word = word;
        row.gap = 8'(gap);
        row.is_illegal = 1'b1;
        rows.push_back(row);
        illegal_rows++;
    endtask

    task automatic build_program();
        for(int r = 0;r < `CORE_REG_NUM;r++) model_regs[r] = '0;
        // operands
        add_op(op_lui, 1'b0, 1, 0, 0, 32'h8000_0000, 1);
        add_op(op_add, 1'b1, 2, 0, 0, lcg_next(), 2);
        add_op(op_add, 1'b1, 3, 0, 0, 32'hffff_fff9, 0);
        add_op(op_lui, 1'b0, 4, 0, 0, lcg_next(), 1);
        add_op(op_add, 1'b1, 4, 4, 0, lcg_next(), 0);
        add_op(op_add, 1'b0, 5, 2, 3, 0, 1);
        add_op(op_sub, 1'b0, 6, 3, 2, 0, 0);
        add_op(op_sll, 1'b0, 7, 4, 3, 0, 2);
        add_op(op_slt, 1'b0, 8, 3, 2, 0, 0);
        add_op(op_sltu, 1'b0, 9, 3, 2, 0, 1);
        add_op(op_xor, 1'b0, 10, 4, 1, 0, 0);
        add_op(op_srl, 1'b0, 11, 1, 3, 0, 0);
        add_op(op_sra, 1'b0, 12, 1, 3, 0, 3);
        add_op(op_or, 1'b0, 13, 2, 4, 0, 0);
        add_op(op_and, 1'b0, 14, 4, 3, 0, 1);
        add_op(op_slt, 1'b1, 15, 3, 0, 1, 0);
        add_op(op_sltu, 1'b1, 16, 3, 0, 5, 0);
        add_op(op_xor, 1'b1, 17, 4, 0, 32'hffff_ffff, 2);
        add_op(op_or, 1'b1, 18, 2, 0, 32'h7f0, 0);
        add_op(op_and, 1'b1, 19, 4, 0, lcg_next(), 1);
        add_op(op_sll, 1'b1, 20, 2, 0, 7, 0);
        add_op(op_srl, 1'b1, 21, 1, 0, 4, 0);
        add_op(op_sra, 1'b1, 22, 1, 0, 4, 1);
        // div, lw, sll with funct7 0x20, ecall
        add_illegal(32'h0200_40b3, 1);
        add_illegal(32'h0000_2083, 0);
        add_illegal(32'h4000_11b3, 0);
        add_illegal(32'h0000_0073, 2);
        // write to x0, then read it back
        add_op(op_add, 1'b1, 0, 4, 0, 33, 0);
        add_op(op_add, 1'b0, 30, 0, 2, 0, 1);
        // dependent multiply early in the zero-gap burst stalls issue and fills the queue
        add_op(op_mul, 1'b0, 23, 4, 3, 0, 0);
        add_op(op_mul, 1'b0, 27, 23, 2, 0, 0);
        // retires ahead of the multiply before it
        add_op(op_add, 1'b1, 28, 2, 0, 1, 0);
        add_op(op_mulhu, 1'b0, 24, 4, 3, 0, 0);
        add_op(op_mul, 1'b0, 25, 1, 2, 0, 0);
        add_op(op_mulhu, 1'b0, 26, 4, 4, 0, 0);
        add_op(op_add, 1'b1, 5, 5, 0, 1, 0);
        add_op(op_add, 1'b1, 5, 5, 0, 1, 0);
        add_op(op_xor, 1'b0, 5, 5, 27, 0, 0);
        add_op(op_add, 1'b1, 29, 28, 0, lcg_next(), 0);
    endtask

    function automatic int outstanding_results();
        int total = 0;
        for(int r = 0;r < `CORE_REG_NUM;r++) total += expected[r].size();
        return total;
    endfunction

    // retire and illegal outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if(arst_n && retire_valid) begin
            if(expected[retire_rd].size() == 0) begin
                errors++;
                $display("retire to x%0d at %0t with value 0x%08h was not expected",
                    retire_rd, $time, retire_data);
            end else begin
                compare_value($sformatf("retire_data x%0d", retire_rd), retire_data,
                    expected[retire_rd].pop_front());
            end
        end
        if(arst_n && illegal) illegal_seen++;
    end

    initial begin
        #1;
        repeat((rows.size() + 50) * 20) @(posedge clk);
        $display("watchdog expired with %0d results never retired", outstanding_results());
        for(int r = 0;r < `CORE_REG_NUM;r++) begin
            if(expected[r].size() != 0)
                $display("x%0d still waits for %0d results", r, expected[r].size());
        end
        $display("errors: %0d", errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        inst = '0;
        inst_valid = 1'b0;
        build_program();
        repeat(2) @(posedge clk);
        @(negedge clk);
        compare_value("inst_ready", 32'(inst_ready), 32'd1);
        compare_value("retire_valid", 32'(retire_valid), 32'd0);
        compare_value("illegal", 32'(illegal), 32'd0);
        arst_n = 1'b1;
        @(negedge clk);
        for(int i = 0;i < rows.size();i++) begin
            if(rows[i].gap != 0) begin
                inst_valid = 1'b0;
                repeat(rows[i].gap) @(negedge clk);
            end
            inst = rows[i].word;
            inst_valid = 1'b1;
            if(!inst_ready) ready_low_seen = 1'b1;
            while(!inst_ready) @(negedge clk);
            // taken at the rising edge in between
            @(negedge clk);
        end
        inst_valid = 1'b0;
        while(outstanding_results() != 0) @(negedge clk);
        // room for stray retires or pulses
        repeat(10) @(negedge clk);
        compare_value("illegal pulse count", 32'(illegal_seen), 32'(illegal_rows));
        compare_value("inst_ready low during burst", 32'(ready_low_seen), 32'd1);
        $display("errors: %0d", errors);
        if(errors == 0) $display("TEST PASS");
        else $display("TEST FAIL");
        $finish;
    end
endmodule

//--- sim.f
+incdir+design
design/core_pkg.sv
design/inst_fifo.sv
design/decode.sv
design/regfile.sv
design/issue.sv
design/execute_alu.sv
design/execute_mul.sv
design/wb.sv
design/core_top.sv
dv/core_top_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module core_top_tb -o core_top_tb_sim &&
./obj_dir/core_top_tb_sim | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
